// ==== hdl/pcw_sys_pkg.sv ====
// PCW system control shared types, port addresses, reset values and colour constants
package pcw_sys_pkg;

    // Plain vector types
    typedef logic [7:0]  byte_t;      // I/O data and register value
    typedef logic [7:0]  io_addr_t;   // Low byte of the I/O address
    typedef logic [15:0] cpu_addr_t;
    typedef logic [6:0]  page_t;      // Page number, up to 128 x 16K
    typedef logic [20:0] ram_addr_t;  // 2MB byte address
    typedef logic [1:0]  colour_t;    // Pixel colour from video
    typedef logic [7:0]  line_t;      // Display line
    typedef logic [17:0] rgb_t;       // 6-6-6
    typedef logic [3:0]  miss_cnt_t;  // Saturating timer miss count

    typedef enum logic [1:0] {
        MEM_256K,  // 4 page bits
        MEM_512K,  // 5 page bits
        MEM_1M,    // 6 page bits
        MEM_2M     // 7 page bits
    } mem_size_e;

    // Code 3 falls back to white
    typedef enum logic [1:0] {
        DISP_WHITE,
        DISP_GREEN,
        DISP_AMBER
    } disp_colour_e;

    typedef enum logic [1:0] {
        FAKE_OFF,
        FAKE_CGA0_LOW,
        FAKE_CGA0_HIGH,
        FAKE_CGA1_HIGH
    } fake_mode_e;

    // F8 write commands, other codes ignored
    typedef enum logic [3:0] {
        CMD_DISK_NMI  = 4'd2,
        CMD_DISK_INT  = 4'd3,
        CMD_DISK_OFF  = 4'd4,   // Disk disconnected from NMI and INT
        CMD_TC_SET    = 4'd5,
        CMD_TC_CLR    = 4'd6,
        CMD_MOTOR_ON  = 4'd9,
        CMD_MOTOR_OFF = 4'd10
    } sys_cmd_e;

    typedef struct packed {
        io_addr_t addr;
        logic     wr;     // Write level
        logic     rd;     // Read level
        byte_t    data;   // Write data
    } io_bus_s;

    typedef struct packed {
        byte_t [3:0] page;  // F0-F3, one per 16K slot
        byte_t       lock;  // F4, CPC read lock in bits 7:4
    } page_regs_s;

    typedef struct packed {
        logic disk_to_nmi;
        logic disk_to_int;
        logic mode_change;  // Single cycle, from commands 3 and 4
    } irq_cmd_s;

    typedef struct packed {
        logic      fdc_latch;
        miss_cnt_t timer_misses;
    } irq_status_s;

    localparam io_addr_t PORT_F0 = 8'hF0;
    localparam io_addr_t PORT_F1 = 8'hF1;
    localparam io_addr_t PORT_F2 = 8'hF2;
    localparam io_addr_t PORT_F3 = 8'hF3;
    localparam io_addr_t PORT_F4 = 8'hF4;
    localparam io_addr_t PORT_F8 = 8'hF8;
    localparam io_addr_t PORT_FF = 8'hFF;  // Fake colour end line

    // Boot mapping, pages 0-3 in PCW mode
    localparam page_regs_s PAGE_REGS_RST = '{
        page: {8'h83, 8'h82, 8'h81, 8'h80},
        lock: 8'hF1
    };

    localparam int OFFSET_W     = 14;  // 16K pages
    localparam int CLEAR_CYCLES = 32;  // Delay from F4 read to timer clear

    localparam rgb_t RGB_BLACK = 18'b000000_000000_000000;
    localparam rgb_t RGB_WHITE = 18'b111111_111111_110111;
    localparam rgb_t RGB_GREEN = 18'b011001_111111_011001;
    localparam rgb_t RGB_AMBER = 18'b111111_101100_000000;

    localparam rgb_t CGA0L_GREEN   = 18'b000000_101011_000000;  // Dark green
    localparam rgb_t CGA0L_RED     = 18'b101011_000000_000000;  // Dark red
    localparam rgb_t CGA0L_BROWN   = 18'b101011_010110_000000;
    localparam rgb_t CGA0H_GREEN   = 18'b010110_111111_010110;  // Light green
    localparam rgb_t CGA0H_RED     = 18'b111111_010110_010110;  // Light red
    localparam rgb_t CGA0H_YELLOW  = 18'b111111_111111_010110;
    localparam rgb_t CGA1H_CYAN    = 18'b010110_111111_111111;
    localparam rgb_t CGA1H_MAGENTA = 18'b111111_010110_111111;

endpackage

// ==== hdl/io_port_regs.sv ====
// I/O port register file with page, lock, command and fake colour ports plus status readback
module io_port_regs (
    input  logic                     clk_sys,
    input  logic                     reset,
    input  pcw_sys_pkg::io_bus_s     io,
    input  pcw_sys_pkg::irq_status_s status,
    input  logic                     vblank,
    input  logic                     ntsc,
    output pcw_sys_pkg::byte_t       rd_data,
    output pcw_sys_pkg::page_regs_s  pages,
    output pcw_sys_pkg::irq_cmd_s    irq_cmd,
    output logic                     timer_clear_start,
    output logic                     fdc_tc,
    output logic                     motor_on,
    output pcw_sys_pkg::line_t       fake_end
);
    import pcw_sys_pkg::*;

    byte_t    status_byte;
    sys_cmd_e cmd;

    // Bit 7 always zero, ntsc inverted
    assign status_byte = {1'b0, vblank, status.fdc_latch, ~ntsc, status.timer_misses};

    // F4 and F8 both return status, nothing else decoded for reads
    always_comb begin
        case (io.addr)
            PORT_F4, PORT_F8: rd_data = status_byte;
            default:          rd_data = 8'hFF;
        endcase
    end

    // Reading F4 also starts the timer clear countdown
    assign timer_clear_start = io.rd && (io.addr == PORT_F4);

    assign cmd = sys_cmd_e'(io.data[3:0]);  // Command in low nibble

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            pages    <= PAGE_REGS_RST;
            irq_cmd  <= '0;
            fdc_tc   <= 1'b0;
            motor_on <= 1'b0;
            fake_end <= '0;
        end else begin
            irq_cmd.mode_change <= 1'b0;  // Pulse default
            if (io.wr) begin
                case (io.addr)
                    PORT_F0, PORT_F1, PORT_F2, PORT_F3: begin
                        pages.page[io.addr[1:0]] <= io.data;  // Slot from low address bits
                    end
                    PORT_F4: pages.lock <= io.data;
                    PORT_FF: fake_end   <= io.data;
                    PORT_F8: begin
                        case (cmd)
                            CMD_DISK_NMI: begin
                                irq_cmd.disk_to_nmi <= 1'b1;
                                irq_cmd.disk_to_int <= 1'b0;
                            end
                            CMD_DISK_INT: begin
                                irq_cmd.disk_to_nmi <= 1'b0;
                                irq_cmd.disk_to_int <= 1'b1;
                                irq_cmd.mode_change <= 1'b1;
                            end
                            CMD_DISK_OFF: begin
                                irq_cmd.disk_to_nmi <= 1'b0;
                                irq_cmd.disk_to_int <= 1'b0;
                                irq_cmd.mode_change <= 1'b1;
                            end
                            CMD_TC_SET:    fdc_tc   <= 1'b1;
                            CMD_TC_CLR:    fdc_tc   <= 1'b0;
                            CMD_MOTOR_ON:  motor_on <= 1'b1;
                            CMD_MOTOR_OFF: motor_on <= 1'b0;
                            default: ;  // Boot end, reset and speaker codes ignored
                        endcase
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== hdl/mem_pager.sv ====
// CPU address to RAM address translation for PCW and CPC paging modes
module mem_pager (
    input  pcw_sys_pkg::cpu_addr_t  cpu_addr,
    input  logic                    mem_wr,
    input  pcw_sys_pkg::mem_size_e  mem_size,
    input  pcw_sys_pkg::page_regs_s pages,
    output pcw_sys_pkg::ram_addr_t  ram_addr
);
    import pcw_sys_pkg::*;

    localparam int SLOT_W = $bits(cpu_addr_t) - OFFSET_W;     // 2 slot bits
    localparam int CPC_W  = 3;                                // CPC bank width
    localparam int CPC_PAD = $bits(ram_addr_t) - CPC_W - OFFSET_W;

    logic [SLOT_W-1:0]   slot;
    logic [OFFSET_W-1:0] offset;
    byte_t               page_reg;
    page_t               page_mask;
    logic                read_lock;
    logic [CPC_W-1:0]    cpc_bank;

    assign slot     = cpu_addr[$bits(cpu_addr_t)-1 -: SLOT_W];
    assign offset   = cpu_addr[OFFSET_W-1:0];
    assign page_reg = pages.page[slot];

    // Lock bit for slot n is F4 bit 4+n
    assign read_lock = pages.lock[{1'b1, slot}];

    // Wrap pages to the fitted memory size
    always_comb begin
        case (mem_size)
            MEM_256K: page_mask = 7'h0F;
            MEM_512K: page_mask = 7'h1F;
            MEM_1M:   page_mask = 7'h3F;
            default:  page_mask = 7'h7F;
        endcase
    end

    // CPC writes always use the low bank field
    // Locked reads follow the write bank, unlocked reads take bits 6:4
    always_comb begin
        if (mem_wr || read_lock) begin
            cpc_bank = page_reg[2:0];
        end else begin
            cpc_bank = page_reg[6:4];
        end
    end

    always_comb begin
        if (page_reg[7]) begin                      // PCW mode
            ram_addr = {page_reg[6:0] & page_mask, offset};
        end else begin                              // CPC mode, low 128K only
            ram_addr = {{CPC_PAD{1'b0}}, cpc_bank, offset};
        end
    end

endmodule

// ==== hdl/irq_timer_ctrl.sv ====
// Timer miss counter, disk interrupt routing and CPU INT/NMI line generation
module irq_timer_ctrl (
    input  logic                     clk_sys,
    input  logic                     reset,
    input  logic                     timer_tick,
    input  logic                     fdc_int,
    input  logic                     int_enable,
    input  pcw_sys_pkg::irq_cmd_s    irq_cmd,
    input  logic                     timer_clear_start,
    output pcw_sys_pkg::irq_status_s status,
    output logic                     int_n,
    output logic                     nmi_n
);
    import pcw_sys_pkg::*;

    localparam int EDGE_TIMER = 0;
    localparam int EDGE_FDC   = 1;
    localparam int CLR_W      = $clog2(CLEAR_CYCLES);

    logic [1:0]       edge_in;
    logic [1:0]       edge_q;     // Inputs registered once
    logic [1:0]       rise;       // Registered rise pulses
    logic             fdc_fall;
    logic             fdc_latch;
    logic             nmi_flag;   // Pending disk NMI
    miss_cnt_t        timer_misses;
    logic             clr_active;
    logic [CLR_W-1:0] clr_cnt;
    logic             timer_line;
    logic             int_line;
    logic             nmi_line;

    assign edge_in = {fdc_int, timer_tick};

    // Pulses land one edge after the input is first sampled high
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            edge_q   <= '0;
            rise     <= '0;
            fdc_fall <= 1'b0;
        end else begin
            edge_q   <= edge_in;
            rise     <= edge_in & ~edge_q;
            fdc_fall <= edge_q[EDGE_FDC] & ~fdc_int;
        end
    end

    // FDC status latch and NMI flag
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            fdc_latch <= 1'b0;
            nmi_flag  <= 1'b0;
        end else begin
            if (rise[EDGE_FDC]) begin
                fdc_latch <= 1'b1;
                if (irq_cmd.disk_to_nmi) nmi_flag <= 1'b1;
            end else if (fdc_fall) begin
                fdc_latch <= 1'b0;
            end
            // INT mode or disconnect drops any pending NMI
            if (irq_cmd.mode_change && !irq_cmd.disk_to_nmi) nmi_flag <= 1'b0;
        end
    end

    // Interrupt lines sampled on the timer tick
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            timer_misses <= '0;
            timer_line   <= 1'b0;
            int_line     <= 1'b0;
            nmi_line     <= 1'b0;
            clr_active   <= 1'b0;
            clr_cnt      <= '0;
        end else begin
            if (rise[EDGE_TIMER]) begin
                if (timer_misses != '1) timer_misses <= timer_misses + 1'b1;  // Sticks at 15
                timer_line <= int_enable;
                nmi_line   <= nmi_flag;
                int_line   <= irq_cmd.disk_to_int & fdc_latch & int_enable;
            end
            if (timer_clear_start) begin            // Every F4 read restarts the count
                clr_active <= 1'b1;
                clr_cnt    <= '0;
            end else if (clr_active) begin
                if (clr_cnt == CLR_W'(CLEAR_CYCLES - 1)) begin
                    clr_active   <= 1'b0;
                    timer_misses <= '0;         // Wins over a tick on the same edge
                    timer_line   <= 1'b0;
                end else begin
                    clr_cnt <= clr_cnt + 1'b1;
                end
            end
            if (irq_cmd.mode_change && !irq_cmd.disk_to_nmi && !irq_cmd.disk_to_int) begin
                int_line <= 1'b0;   // Disconnect
            end
        end
    end

    assign status = '{fdc_latch: fdc_latch, timer_misses: timer_misses};

    assign nmi_n = ~nmi_line;
    assign int_n = nmi_line | ~(int_line | timer_line);  // INT held off behind NMI

endmodule

// ==== hdl/colour_mapper.sv ====
// Pixel colour to 18-bit RGB with monochrome tints and CGA style fake colour palettes
module colour_mapper (
    input  pcw_sys_pkg::colour_t      colour,
    input  pcw_sys_pkg::line_t        ypos,
    input  pcw_sys_pkg::line_t        fake_end,
    input  pcw_sys_pkg::disp_colour_e disp_colour,
    input  pcw_sys_pkg::fake_mode_e   fake_mode,
    output pcw_sys_pkg::rgb_t         rgb
);
    import pcw_sys_pkg::*;

    rgb_t tint;
    rgb_t mono;
    rgb_t fake;
    logic fake_area;

    always_comb begin
        case (disp_colour)
            DISP_GREEN: tint = RGB_GREEN;
            DISP_AMBER: tint = RGB_AMBER;
            default:    tint = RGB_WHITE;   // White and unused code
        endcase
    end

    // Any lit pixel takes the full tint
    assign mono = (colour == 2'd0) ? RGB_BLACK : tint;

    always_comb begin
        fake = mono;
        case (fake_mode)
            FAKE_CGA0_LOW: begin
                case (colour)
                    2'd1:    fake = CGA0L_GREEN;
                    2'd2:    fake = CGA0L_RED;
                    2'd3:    fake = CGA0L_BROWN;
                    default: fake = RGB_BLACK;
                endcase
            end
            FAKE_CGA0_HIGH: begin
                case (colour)
                    2'd1:    fake = CGA0H_GREEN;
                    2'd2:    fake = CGA0H_RED;
                    2'd3:    fake = CGA0H_YELLOW;
                    default: fake = RGB_BLACK;
                endcase
            end
            FAKE_CGA1_HIGH: begin
                case (colour)
                    2'd1:    fake = CGA1H_CYAN;
                    2'd2:    fake = CGA1H_MAGENTA;
                    2'd3:    fake = RGB_WHITE;      // White tint regardless of disp_colour
                    default: fake = RGB_BLACK;
                endcase
            end
            default: ;  // Off keeps mono
        endcase
    end

    // Palette only above the programmed line
    assign fake_area = (fake_mode != FAKE_OFF) && (ypos < fake_end);

    assign rgb = fake_area ? fake : mono;

endmodule

// ==== hdl/pcw_sys_ctrl.sv ====
// PCW system control top joining port registers, pager, interrupt control and colour mapping
module pcw_sys_ctrl (
    input  logic                      clk_sys,
    input  logic                      reset,
    input  pcw_sys_pkg::io_bus_s      io,
    input  pcw_sys_pkg::cpu_addr_t    cpu_addr,
    input  logic                      mem_wr,
    input  pcw_sys_pkg::mem_size_e    mem_size,
    input  pcw_sys_pkg::disp_colour_e disp_colour,
    input  pcw_sys_pkg::fake_mode_e   fake_mode,
    input  logic                      ntsc,
    input  logic                      vblank,
    input  logic                      timer_tick,
    input  logic                      fdc_int,
    input  logic                      int_enable,
    input  pcw_sys_pkg::colour_t      colour,
    input  pcw_sys_pkg::line_t        ypos,
    output pcw_sys_pkg::byte_t        rd_data,
    output pcw_sys_pkg::ram_addr_t    ram_addr,
    output logic                      int_n,
    output logic                      nmi_n,
    output logic                      fdc_tc,
    output logic                      motor_on,
    output pcw_sys_pkg::rgb_t         rgb
);
    import pcw_sys_pkg::*;

    page_regs_s  pages;
    irq_cmd_s    irq_cmd;
    irq_status_s status;             // Back from interrupt control for F8 reads
    logic        timer_clear_start;
    line_t       fake_end;

    io_port_regs i_io_port_regs (
        .clk_sys           (clk_sys),
        .reset             (reset),
        .io                (io),
        .status            (status),
        .vblank            (vblank),
        .ntsc              (ntsc),
        .rd_data           (rd_data),
        .pages             (pages),
        .irq_cmd           (irq_cmd),
        .timer_clear_start (timer_clear_start),
        .fdc_tc            (fdc_tc),
        .motor_on          (motor_on),
        .fake_end          (fake_end)
    );

    mem_pager i_mem_pager (
        .cpu_addr (cpu_addr),
        .mem_wr   (mem_wr),
        .mem_size (mem_size),
        .pages    (pages),
        .ram_addr (ram_addr)
    );

    irq_timer_ctrl i_irq_timer_ctrl (
        .clk_sys           (clk_sys),
        .reset             (reset),
        .timer_tick        (timer_tick),
        .fdc_int           (fdc_int),
        .int_enable        (int_enable),
        .irq_cmd           (irq_cmd),
        .timer_clear_start (timer_clear_start),
        .status            (status),
        .int_n             (int_n),
        .nmi_n             (nmi_n)
    );

    colour_mapper i_colour_mapper (
        .colour      (colour),
        .ypos        (ypos),
        .fake_end    (fake_end),
        .disp_colour (disp_colour),
        .fake_mode   (fake_mode),
        .rgb         (rgb)
    );

endmodule

// ==== verification/tb_pcw_sys_ctrl.sv ====
// Directed testbench for the PCW system control block covering ports, paging, interrupts and colour
module tb_pcw_sys_ctrl;
    timeunit 1ns;
    timeprecision 1ps;
    import pcw_sys_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int CLEAR_DELAY  = 32;                // F4 read to timer clear
    localparam int TEST_CYCLES  = 650;               // Rough sum over the five tests
    localparam int MAX_CYCLES   = 2 * TEST_CYCLES;

    logic         clk_sys     = 1'b0;
    logic         reset       = 1'b1;
    io_bus_s      io          = '0;
    cpu_addr_t    cpu_addr    = '0;
    logic         mem_wr      = 1'b0;
    mem_size_e    mem_size    = MEM_256K;
    disp_colour_e disp_colour = DISP_WHITE;
    fake_mode_e   fake_mode   = FAKE_OFF;
    logic         ntsc        = 1'b0;
    logic         vblank      = 1'b1;
    logic         timer_tick  = 1'b0;
    logic         fdc_int     = 1'b0;
    logic         int_enable  = 1'b0;
    colour_t      colour      = '0;
    line_t        ypos        = '0;
    byte_t        rd_data;
    ram_addr_t    ram_addr;
    logic         int_n;
    logic         nmi_n;
    logic         fdc_tc;
    logic         motor_on;
    rgb_t         rgb;

    logic [15:0]  lfsr = 16'd65;      // Galois LFSR state
    byte_t        page_model [4];     // F0-F3 as last written
    byte_t        lock_model;
    int           errors    = 0;
    int           tests_run = 0;
    int           cycles    = 0;

    pcw_sys_ctrl i_pcw_sys_ctrl (.*);

    initial begin
        forever #5 clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout, run stopped after %0d cycles", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // Galois form of x^16 + x^14 + x^13 + x^11 + 1
    // One step per bit taken
    function automatic logic [31:0] random_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Page register picked by the top two address bits
    function automatic ram_addr_t ram_model(cpu_addr_t a, logic wr, int size);
        byte_t      p;
        page_t      mask;
        logic [2:0] bank;
        p    = page_model[a[15:14]];
        mask = page_t'((1 << (4 + size)) - 1);            // 4 to 7 page bits
        bank = (wr || lock_model[4 + a[15:14]]) ? p[2:0] : p[6:4];
        if (p[7]) return {p[6:0] & mask, a[13:0]};        // PCW mode
        return {4'b0000, bank, a[13:0]};                  // CPC mode
    endfunction

    function automatic rgb_t rgb_model(disp_colour_e d, fake_mode_e m, colour_t c,
                                       line_t y, line_t fend);
        rgb_t tint;
        rgb_t pal [4];
        tint = (d == DISP_GREEN) ? RGB_GREEN : (d == DISP_AMBER) ? RGB_AMBER : RGB_WHITE;
        case (m)
            FAKE_CGA0_LOW:  pal = '{RGB_BLACK, CGA0L_GREEN, CGA0L_RED, CGA0L_BROWN};
            FAKE_CGA0_HIGH: pal = '{RGB_BLACK, CGA0H_GREEN, CGA0H_RED, CGA0H_YELLOW};
            default:        pal = '{RGB_BLACK, CGA1H_CYAN, CGA1H_MAGENTA, RGB_WHITE};
        endcase
        if (m != FAKE_OFF && y < fend) return pal[c];
        return (c == 2'd0) ? RGB_BLACK : tint;
    endfunction

    // Zero, vblank, latch, inverted ntsc, misses
    function automatic byte_t status_model(logic latch, miss_cnt_t misses);
        return {1'b0, vblank, latch, ~ntsc, misses};
    endfunction

    task automatic report_error(string name, logic [31:0] exp, logic [31:0] act);
        errors++;
        $display("Error %s expected %0h got %0h at %0t", name, exp, act, $time);
    endtask

    task automatic write_port(io_addr_t port, byte_t data);
        @(posedge clk_sys);
        io <= '{addr: port, wr: 1'b1, rd: 1'b0, data: data};
        @(posedge clk_sys);                              // Register loads here
        io.wr <= 1'b0;
    endtask

    task automatic check_read(io_addr_t port, byte_t exp);
        @(posedge clk_sys);
        io <= '{addr: port, wr: 1'b0, rd: 1'b1, data: 8'h00};
        @(negedge clk_sys);
        if (rd_data !== exp) report_error("rd_data", 32'(exp), 32'(rd_data));
        @(posedge clk_sys);
        io.rd <= 1'b0;
    endtask

    task automatic check_mapping(cpu_addr_t a, logic wr, int size);
        ram_addr_t exp;
        exp = ram_model(a, wr, size);
        @(posedge clk_sys);
        cpu_addr <= a;
        mem_wr   <= wr;
        mem_size <= mem_size_e'(size[1:0]);
        @(negedge clk_sys);
        if (ram_addr !== exp) report_error("ram_addr", 32'(exp), 32'(ram_addr));
    endtask

    task automatic check_irq(logic exp_int_n, logic exp_nmi_n);
        @(negedge clk_sys);
        if (int_n !== exp_int_n) report_error("int_n", 32'(exp_int_n), 32'(int_n));
        if (nmi_n !== exp_nmi_n) report_error("nmi_n", 32'(exp_nmi_n), 32'(nmi_n));
    endtask

    task automatic pulse_tick();
        @(posedge clk_sys);
        timer_tick <= 1'b1;
        repeat (2) @(posedge clk_sys);                   // Update on the second edge
        timer_tick <= 1'b0;
        repeat (2) @(posedge clk_sys);
    endtask

    task automatic drive_fdc(logic level);
        @(posedge clk_sys);
        fdc_int <= level;
        repeat (3) @(posedge clk_sys);                   // Latch settled
    endtask

    task automatic reset_state();
        tests_run++;
        page_model = '{8'h80, 8'h81, 8'h82, 8'h83};
        lock_model = 8'hF1;
        check_read(PORT_F4, status_model(1'b0, 4'd0));
        check_read(PORT_F8, status_model(1'b0, 4'd0));
        @(posedge clk_sys);
        vblank <= 1'b0;
        ntsc   <= 1'b1;
        @(negedge clk_sys);
        check_read(PORT_F8, status_model(1'b0, 4'd0));
        check_irq(1'b1, 1'b1);
        for (int s = 0; s < 4; s++) begin                // Every mem_size mask
            for (int k = 0; k < 4; k++) begin
                check_mapping(cpu_addr_t'(random_bits(16)), 1'(random_bits(1)), s);
            end
        end
    endtask

    task automatic cpc_paging();
        io_addr_t a;
        tests_run++;
        for (int i = 0; i < 4; i++) begin
            if (i == 3) begin
                page_model[i] = {4'hF, 4'(random_bits(4))};  // PCW page, bits 6:4 split the masks
            end else begin
                page_model[i] = {1'b0, 7'(random_bits(7))};  // CPC banks
            end
            write_port(PORT_F0 + io_addr_t'(i), page_model[i]);
        end
        lock_model = byte_t'(random_bits(8));
        write_port(PORT_F4, lock_model);
        for (int k = 0; k < 16; k++) begin
            check_mapping(cpu_addr_t'(random_bits(16)), 1'(random_bits(1)), int'(random_bits(2)));
        end
        for (int s = 0; s < 4; s++) begin                // F3 slot under each mask
            check_mapping({2'b11, 14'(random_bits(14))}, 1'(random_bits(1)), s);
        end
        check_read(8'hF5, 8'hFF);                        // Old video port
        check_read(PORT_FF, 8'hFF);
        for (int k = 0; k < 4; k++) begin
            a = io_addr_t'(random_bits(8));
            if (a == PORT_F4 || a == PORT_F8) a = PORT_F0;
            check_read(a, 8'hFF);
        end
    endtask

    task automatic timer_saturation();
        tests_run++;
        repeat (CLEAR_DELAY) @(posedge clk_sys);         // Earlier F4 read long expired
        pulse_tick();                                    // int_enable still low
        check_irq(1'b1, 1'b1);
        @(posedge clk_sys);
        int_enable <= 1'b1;
        pulse_tick();
        check_irq(1'b0, 1'b1);
        repeat (19) pulse_tick();
        check_read(PORT_F8, status_model(1'b0, 4'hF));   // Saturated
        check_read(PORT_F4, status_model(1'b0, 4'hF));
        repeat (CLEAR_DELAY - 1) @(posedge clk_sys);
        check_irq(1'b0, 1'b1);                           // One edge before the clear
        @(posedge clk_sys);
        check_irq(1'b1, 1'b1);
        check_read(PORT_F8, status_model(1'b0, 4'h0));
    endtask

    task automatic disk_routing();
        byte_t cmds [4]      = '{8'd5, 8'd9, 8'd6, 8'd10};
        logic  tc_exp [4]    = '{1'b1, 1'b1, 1'b0, 1'b0};
        logic  motor_exp [4] = '{1'b0, 1'b1, 1'b1, 1'b0};
        tests_run++;
        write_port(PORT_F8, 8'd2);                       // Disk to NMI
        drive_fdc(1'b1);
        pulse_tick();
        check_irq(1'b1, 1'b0);                           // NMI holds INT off
        check_read(PORT_F8, status_model(1'b1, 4'd1));
        drive_fdc(1'b0);
        check_read(PORT_F8, status_model(1'b0, 4'd1));   // Latch dropped on the fall
        write_port(PORT_F8, 8'd3);                       // Disk to INT
        drive_fdc(1'b1);
        pulse_tick();
        check_irq(1'b0, 1'b1);
        check_read(PORT_F4, status_model(1'b1, 4'd2));
        repeat (CLEAR_DELAY) @(posedge clk_sys);
        check_irq(1'b0, 1'b1);                           // Disk INT still up after the clear
        write_port(PORT_F8, 8'd4);                       // Disconnect
        @(posedge clk_sys);
        check_irq(1'b1, 1'b1);
        for (int i = 0; i < 4; i++) begin
            write_port(PORT_F8, cmds[i]);
            @(negedge clk_sys);
            if (fdc_tc !== tc_exp[i]) report_error("fdc_tc", 32'(tc_exp[i]), 32'(fdc_tc));
            if (motor_on !== motor_exp[i]) begin
                report_error("motor_on", 32'(motor_exp[i]), 32'(motor_on));
            end
        end
    endtask

    task automatic colour_sweep(line_t fend);
        disp_colour_e d;
        fake_mode_e   m;
        line_t        y;
        rgb_t         exp;
        for (int i = 0; i < 128; i++) begin
            d   = disp_colour_e'(i[6:5]);
            m   = fake_mode_e'(i[4:3]);
            y   = i[0] ? fend : fend - 8'd1;             // Alternates last palette and first mono line
            exp = rgb_model(d, m, i[2:1], y, fend);
            @(posedge clk_sys);
            disp_colour <= d;
            fake_mode   <= m;
            colour      <= i[2:1];
            ypos        <= y;
            @(negedge clk_sys);
            if (rgb !== exp) report_error("rgb", 32'(exp), 32'(rgb));
        end
    endtask

    task automatic colour_mapping();
        line_t fend;
        tests_run++;
        colour_sweep(8'd0);                              // Tints only with fake_end at reset
        fend = {1'b1, 7'(random_bits(7))};
        write_port(PORT_FF, fend);
        colour_sweep(fend);
    endtask

    initial begin
        repeat (RESET_CYCLES) @(posedge clk_sys);
        reset <= 1'b0;
        reset_state();
        cpc_paging();
        timer_saturation();
        disk_routing();
        colour_mapping();
        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
hdl/pcw_sys_pkg.sv
hdl/io_port_regs.sv
hdl/mem_pager.sv
hdl/irq_timer_ctrl.sv
hdl/colour_mapper.sv
hdl/pcw_sys_ctrl.sv
verification/tb_pcw_sys_ctrl.sv

// ==== Makefile ====
# Verilator build and run for the PCW system control testbench

TOP       ?= tb_pcw_sys_ctrl
FILELIST  ?= verilog.f
VERILATOR ?= verilator
BUILD_DIR ?= obj_dir
FLAGS     ?= --binary --timing -j 0
PASS_MSG  := TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
